// ==== src/axi4s_split_join.sv ====
/*
 * Header split/join stage.
 * Splits packet headers out to an external processor, buffers the
 * payload and rejoins them. Optional register slices on all four ports.
 */
`timescale 1ns/1ps

module axi4s_split_join #(
   parameter int FIFO_DEPTH   = 64,
   parameter bit IN_PIPE      = 1'b1,
   parameter bit OUT_PIPE     = 1'b1,
   parameter bit HDR_IN_PIPE  = 1'b1,
   parameter bit HDR_OUT_PIPE = 1'b1
) (
   input  logic                              axi4s_in,
   input  logic                              arst_n,
   input  logic                              in_valid,
   output logic                              in_ready,
   input  logic [split_join_pkg::DATA_W-1:0] in_data,
   input  logic                              in_last,
   output logic                              out_valid,
   input  logic                              out_ready,
   output logic [split_join_pkg::DATA_W-1:0] out_data,
   output logic                              out_last,
   output logic                              hdr_out_valid,
   input  logic                              hdr_out_ready,
   output logic [split_join_pkg::DATA_W-1:0] hdr_out_data,
   output logic                              hdr_out_last,
   output logic [split_join_pkg::TID_W-1:0]  hdr_out_tid,
   output logic                              hdr_out_has_pyld,
   input  logic                              hdr_in_valid,
   output logic                              hdr_in_ready,
   input  logic [split_join_pkg::DATA_W-1:0] hdr_in_data,
   input  logic                              hdr_in_last,
   input  logic [split_join_pkg::TID_W-1:0]  hdr_in_tid,
   input  logic                              hdr_in_has_pyld,
   input  logic                              wb_cyc,
   input  logic                              wb_stb,
   input  logic                              wb_we,
   input  logic [split_join_pkg::WB_AW-1:0]  wb_adr,
   input  logic [split_join_pkg::WB_DW-1:0]  wb_dat_w,
   output logic                              wb_ack,
   output logic [split_join_pkg::WB_DW-1:0]  wb_dat_r
);
   import split_join_pkg::*;

   // s_: into the splitter, sh_/sp_: splitter outputs, fr_: FIFO read side,
   // jh_: returned header into the joiner, jo_: joiner output.
   logic s_valid, s_ready, s_last;
   logic [DATA_W-1:0] s_data;
   logic sh_valid, sh_ready, sh_last, sh_has_pyld;
   logic [DATA_W-1:0] sh_data;
   logic [TID_W-1:0] sh_tid;
   logic sp_valid, sp_ready, sp_last;
   logic [DATA_W-1:0] sp_data;
   logic [TID_W-1:0] sp_tid;
   logic fr_valid, fr_ready, fr_last;
   logic [DATA_W-1:0] fr_data;
   logic [TID_W-1:0] fr_tid;
   logic jh_valid, jh_ready, jh_last, jh_has_pyld;
   logic [DATA_W-1:0] jh_data;
   logic [TID_W-1:0] jh_tid;
   logic jo_valid, jo_ready, jo_last;
   logic [DATA_W-1:0] jo_data;
   logic [HDR_WORDS_W-1:0] hdr_words;
   logic enable;
   logic mismatch_evt;

   // ------------------------------------------------------------------
   // optional port slices
   // ------------------------------------------------------------------
   if (IN_PIPE) begin : g_in_pipe
      stream_pipe #(.W(STRM_W)) u_pipe (
         .axi4s_in, .arst_n,
         .s_valid(in_valid), .s_ready(in_ready), .s_data({in_last, in_data}),
         .m_valid(s_valid), .m_ready(s_ready), .m_data({s_last, s_data}));
   end else begin : g_in_wire
      assign {s_valid, s_last, s_data} = {in_valid, in_last, in_data};
      assign in_ready = s_ready;
   end

   if (HDR_OUT_PIPE) begin : g_hdr_out_pipe
      stream_pipe #(.W(HDR_STRM_W)) u_pipe (
         .axi4s_in, .arst_n,
         .s_valid(sh_valid), .s_ready(sh_ready),
         .s_data({sh_has_pyld, sh_tid, sh_last, sh_data}),
         .m_valid(hdr_out_valid), .m_ready(hdr_out_ready),
         .m_data({hdr_out_has_pyld, hdr_out_tid, hdr_out_last, hdr_out_data}));
   end else begin : g_hdr_out_wire
      assign {hdr_out_valid, hdr_out_has_pyld, hdr_out_tid, hdr_out_last, hdr_out_data} =
         {sh_valid, sh_has_pyld, sh_tid, sh_last, sh_data};
      assign sh_ready = hdr_out_ready;
   end

   if (HDR_IN_PIPE) begin : g_hdr_in_pipe
      stream_pipe #(.W(HDR_STRM_W)) u_pipe (
         .axi4s_in, .arst_n,
         .s_valid(hdr_in_valid), .s_ready(hdr_in_ready),
         .s_data({hdr_in_has_pyld, hdr_in_tid, hdr_in_last, hdr_in_data}),
         .m_valid(jh_valid), .m_ready(jh_ready),
         .m_data({jh_has_pyld, jh_tid, jh_last, jh_data}));
   end else begin : g_hdr_in_wire
      assign {jh_valid, jh_has_pyld, jh_tid, jh_last, jh_data} =
         {hdr_in_valid, hdr_in_has_pyld, hdr_in_tid, hdr_in_last, hdr_in_data};
      assign hdr_in_ready = jh_ready;
   end

   if (OUT_PIPE) begin : g_out_pipe
      stream_pipe #(.W(STRM_W)) u_pipe (
         .axi4s_in, .arst_n,
         .s_valid(jo_valid), .s_ready(jo_ready), .s_data({jo_last, jo_data}),
         .m_valid(out_valid), .m_ready(out_ready), .m_data({out_last, out_data}));
   end else begin : g_out_wire
      assign {out_valid, out_last, out_data} = {jo_valid, jo_last, jo_data};
      assign jo_ready = out_ready;
   end

   // ------------------------------------------------------------------
   // split, buffer, join and registers
   // ------------------------------------------------------------------
   hdr_split u_split (
      .axi4s_in, .arst_n, .hdr_words, .enable,
      .in_valid(s_valid), .in_ready(s_ready), .in_data(s_data), .in_last(s_last),
      .hdr_valid(sh_valid), .hdr_ready(sh_ready), .hdr_data(sh_data),
      .hdr_last(sh_last), .hdr_tid(sh_tid), .hdr_has_pyld(sh_has_pyld),
      .pyld_valid(sp_valid), .pyld_ready(sp_ready), .pyld_data(sp_data),
      .pyld_last(sp_last), .pyld_tid(sp_tid));

   pyld_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
      .axi4s_in, .arst_n,
      .wr_valid(sp_valid), .wr_ready(sp_ready), .wr_data(sp_data),
      .wr_last(sp_last), .wr_tid(sp_tid),
      .rd_valid(fr_valid), .rd_ready(fr_ready), .rd_data(fr_data),
      .rd_last(fr_last), .rd_tid(fr_tid));

   hdr_join u_join (
      .axi4s_in, .arst_n,
      .hdr_valid(jh_valid), .hdr_ready(jh_ready), .hdr_data(jh_data),
      .hdr_last(jh_last), .hdr_tid(jh_tid), .hdr_has_pyld(jh_has_pyld),
      .pyld_valid(fr_valid), .pyld_ready(fr_ready), .pyld_data(fr_data),
      .pyld_last(fr_last), .pyld_tid(fr_tid),
      .out_valid(jo_valid), .out_ready(jo_ready), .out_data(jo_data),
      .out_last(jo_last), .mismatch_evt);

   split_join_regs u_regs (
      .axi4s_in, .arst_n, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w,
      .wb_ack, .wb_dat_r, .hdr_words, .enable, .mismatch_evt);

endmodule

// ==== src/hdr_join.sv ====
/*
 * Header joiner.
 * Sends each processed header and then the stored payload of the same
 * packet, and flags a tag mismatch between the two halves.
 */
`timescale 1ns/1ps

module hdr_join (
   input  logic                              axi4s_in,
   input  logic                              arst_n,
   input  logic                              hdr_valid,
   output logic                              hdr_ready,
   input  logic [split_join_pkg::DATA_W-1:0] hdr_data,
   input  logic                              hdr_last,
   input  logic [split_join_pkg::TID_W-1:0]  hdr_tid,
   input  logic                              hdr_has_pyld,
   input  logic                              pyld_valid,
   output logic                              pyld_ready,
   input  logic [split_join_pkg::DATA_W-1:0] pyld_data,
   input  logic                              pyld_last,
   input  logic [split_join_pkg::TID_W-1:0]  pyld_tid,
   output logic                              out_valid,
   input  logic                              out_ready,
   output logic [split_join_pkg::DATA_W-1:0] out_data,
   output logic                              out_last,
   output logic                              mismatch_evt
);
   import split_join_pkg::*;

   logic             in_pyld;
   logic             pyld_first;
   logic [TID_W-1:0] exp_tid;
   logic             out_can;
   logic             hdr_take;
   logic             pyld_take;

   assign out_can    = !out_valid || out_ready;
   assign hdr_ready  = !in_pyld && out_can;
   assign pyld_ready = in_pyld && out_can;
   assign hdr_take   = hdr_valid && hdr_ready;
   assign pyld_take  = pyld_valid && pyld_ready;

   // ------------------------------------------------------------------
   // header words first, then the matching payload
   // ------------------------------------------------------------------
   always_ff @(posedge axi4s_in or negedge arst_n) begin
      if (!arst_n) begin
         in_pyld      <= 1'b0;
         pyld_first   <= 1'b0;
         out_valid    <= 1'b0;
         mismatch_evt <= 1'b0;
      end else begin
         mismatch_evt <= 1'b0;
         if (out_ready) out_valid <= 1'b0;
         if (hdr_take) begin
            out_valid <= 1'b1;
            if (hdr_last && hdr_has_pyld) begin
               in_pyld    <= 1'b1;
               pyld_first <= 1'b1;
            end
         end
         if (pyld_take) begin
            out_valid  <= 1'b1;
            pyld_first <= 1'b0;
            // data keeps flowing even when the tags disagree.
            mismatch_evt <= pyld_first && (pyld_tid != exp_tid);
            if (pyld_last) in_pyld <= 1'b0;
         end
      end
   end

   always_ff @(posedge axi4s_in) begin
      if (hdr_take) begin
         out_data <= hdr_data;
         out_last <= hdr_last && !hdr_has_pyld;
         exp_tid  <= hdr_tid;
      end else if (pyld_take) begin
         out_data <= pyld_data;
         out_last <= pyld_last;
      end
   end

   // the header word that hands over to the payload does not close the packet.
   a_pyld_order: assert property (@(posedge axi4s_in) disable iff (!arst_n)
      $rose(in_pyld) |-> out_valid && !out_last);

endmodule

// ==== src/hdr_split.sv ====
/*
 * Header splitter.
 * Routes the first hdr_words words of each packet to the header stream
 * and the rest to the payload stream, tagging both with a sequence tag.
 */
`timescale 1ns/1ps

module hdr_split (
   input  logic                                   axi4s_in,
   input  logic                                   arst_n,
   input  logic [split_join_pkg::HDR_WORDS_W-1:0] hdr_words,
   input  logic                                   enable,
   input  logic                                   in_valid,
   output logic                                   in_ready,
   input  logic [split_join_pkg::DATA_W-1:0]      in_data,
   input  logic                                   in_last,
   output logic                                   hdr_valid,
   input  logic                                   hdr_ready,
   output logic [split_join_pkg::DATA_W-1:0]      hdr_data,
   output logic                                   hdr_last,
   output logic [split_join_pkg::TID_W-1:0]       hdr_tid,
   output logic                                   hdr_has_pyld,
   output logic                                   pyld_valid,
   input  logic                                   pyld_ready,
   output logic [split_join_pkg::DATA_W-1:0]      pyld_data,
   output logic                                   pyld_last,
   output logic [split_join_pkg::TID_W-1:0]       pyld_tid
);
   import split_join_pkg::*;

   logic                   first;
   logic                   cur_en;
   logic [HDR_WORDS_W-1:0] cur_words;
   logic [HDR_WORDS_W-1:0] word_cnt;
   logic [TID_W-1:0]       tag;
   logic                   eff_en;
   logic [HDR_WORDS_W-1:0] eff_words;
   logic                   to_hdr;
   logic                   hdr_end;
   logic                   take;

   // hdr_words and enable are sampled on the first word and held for the packet.
   assign eff_en    = first ? enable : cur_en;
   assign eff_words = first ? hdr_words : cur_words;
   assign to_hdr    = !eff_en || (word_cnt < eff_words);
   assign hdr_end   = eff_en && (word_cnt == eff_words - 1'b1);
   assign in_ready  = to_hdr ? (!hdr_valid || hdr_ready) : (!pyld_valid || pyld_ready);
   assign take      = in_valid && in_ready;

   always_ff @(posedge axi4s_in or negedge arst_n) begin
      if (!arst_n) begin
         first      <= 1'b1;
         cur_en     <= 1'b0;
         cur_words  <= '0;
         word_cnt   <= '0;
         tag        <= '0;
         hdr_valid  <= 1'b0;
         pyld_valid <= 1'b0;
      end else begin
         if (hdr_ready) hdr_valid <= 1'b0;
         if (pyld_ready) pyld_valid <= 1'b0;
         if (take) begin
            if (first) begin
               cur_en    <= enable;
               cur_words <= hdr_words;
            end
            first <= in_last;
            if (to_hdr) begin
               hdr_valid <= 1'b1;
               word_cnt  <= word_cnt + 1'b1;
            end else begin
               pyld_valid <= 1'b1;
            end
            if (in_last) begin
               word_cnt <= '0;
               tag      <= tag + 1'b1;
            end
         end
      end
   end

   // header last falls on the final header word or an early packet end.
   always_ff @(posedge axi4s_in) begin
      if (take && to_hdr) begin
         hdr_data     <= in_data;
         hdr_last     <= in_last || hdr_end;
         hdr_has_pyld <= hdr_end && !in_last;
         hdr_tid      <= tag;
      end
      if (take && !to_hdr) begin
         pyld_data <= in_data;
         pyld_last <= in_last;
         pyld_tid  <= tag;
      end
   end

   // a packet started with splitting disabled never reaches the payload side.
   a_no_pyld: assert property (@(posedge axi4s_in) disable iff (!arst_n)
      $rose(pyld_valid) |-> cur_en);

endmodule

// ==== src/pyld_fifo.sv ====
/*
 * Payload FIFO.
 * Circular buffer of payload words with their last flag and tag.
 * Back-pressures the writer when full.
 */
`timescale 1ns/1ps

module pyld_fifo #(
   parameter int FIFO_DEPTH = 64
) (
   input  logic                              axi4s_in,
   input  logic                              arst_n,
   input  logic                              wr_valid,
   output logic                              wr_ready,
   input  logic [split_join_pkg::DATA_W-1:0] wr_data,
   input  logic                              wr_last,
   input  logic [split_join_pkg::TID_W-1:0]  wr_tid,
   output logic                              rd_valid,
   input  logic                              rd_ready,
   output logic [split_join_pkg::DATA_W-1:0] rd_data,
   output logic                              rd_last,
   output logic [split_join_pkg::TID_W-1:0]  rd_tid
);
   import split_join_pkg::*;

   localparam int AW = $clog2(FIFO_DEPTH);
   localparam int EW = DATA_W + TID_W + 1;

   logic [EW-1:0] mem [FIFO_DEPTH];
   logic [AW:0]   wr_ptr;
   logic [AW:0]   rd_ptr;
   logic [AW:0]   used;
   logic          full;
   logic          empty;

   // the extra pointer bit tells a full buffer from an empty one.
   assign empty    = (wr_ptr == rd_ptr);
   assign full     = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
   assign used     = wr_ptr - rd_ptr;
   assign wr_ready = !full;
   assign rd_valid = !empty;
   assign {rd_tid, rd_last, rd_data} = mem[rd_ptr[AW-1:0]];

   always_ff @(posedge axi4s_in or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (wr_valid && wr_ready) wr_ptr <= wr_ptr + 1'b1;
         if (rd_valid && rd_ready) rd_ptr <= rd_ptr + 1'b1;
      end
   end

   always_ff @(posedge axi4s_in) begin
      if (wr_valid && wr_ready) begin
         mem[wr_ptr[AW-1:0]] <= {wr_tid, wr_last, wr_data};
      end
   end

   // a write accepted while full would push the occupancy past the depth.
   a_no_overflow: assert property (@(posedge axi4s_in) disable iff (!arst_n)
      used <= FIFO_DEPTH);

endmodule

// ==== src/split_join_pkg.sv ====
/*
 * Split/join shared definitions.
 * Stream and Wishbone widths, register word addresses and the packed
 * field widths carried through the optional register slices.
 */
package split_join_pkg;

   // ------------------------------------------------------------------
   // stream widths
   // ------------------------------------------------------------------
   localparam int DATA_W      = 64;
   localparam int TID_W       = 4;
   localparam int HDR_WORDS_W = 8;

   // data and last on the in/out streams.
   localparam int STRM_W      = DATA_W + 1;
   // data, last, tid and has_pyld on the header streams.
   localparam int HDR_STRM_W  = DATA_W + TID_W + 2;

   // ------------------------------------------------------------------
   // register bus
   // ------------------------------------------------------------------
   localparam int WB_AW = 2;
   localparam int WB_DW = 32;
   localparam int CNT_W = 16;

   localparam logic [WB_AW-1:0] ADDR_CTRL         = 2'd0;
   localparam logic [WB_AW-1:0] ADDR_STATUS       = 2'd1;
   localparam logic [WB_AW-1:0] ADDR_MISMATCH_CNT = 2'd2;

endpackage

// ==== src/split_join_regs.sv ====
/*
 * Split/join register block.
 * Wishbone classic slave holding hdr_words, the sticky mismatch flag
 * (cleared on read) and a saturating mismatch counter.
 */
`timescale 1ns/1ps

module split_join_regs (
   input  logic                                   axi4s_in,
   input  logic                                   arst_n,
   input  logic                                   wb_cyc,
   input  logic                                   wb_stb,
   input  logic                                   wb_we,
   input  logic [split_join_pkg::WB_AW-1:0]       wb_adr,
   input  logic [split_join_pkg::WB_DW-1:0]       wb_dat_w,
   output logic                                   wb_ack,
   output logic [split_join_pkg::WB_DW-1:0]       wb_dat_r,
   output logic [split_join_pkg::HDR_WORDS_W-1:0] hdr_words,
   output logic                                   enable,
   input  logic                                   mismatch_evt
);
   import split_join_pkg::*;

   logic             req;
   logic             mismatch_flag;
   logic [CNT_W-1:0] mismatch_cnt;

   assign req = wb_cyc && wb_stb && !wb_ack;

   always_ff @(posedge axi4s_in or negedge arst_n) begin
      if (!arst_n) begin
         wb_ack        <= 1'b0;
         hdr_words     <= '0;
         enable        <= 1'b0;
         mismatch_flag <= 1'b0;
         mismatch_cnt  <= '0;
      end else begin
         wb_ack <= req;
         // the write lands at the end of the ack cycle.
         if (wb_ack && wb_cyc && wb_stb && wb_we && wb_adr == ADDR_CTRL) begin
            hdr_words <= wb_dat_w[HDR_WORDS_W-1:0];
            enable    <= (wb_dat_w[HDR_WORDS_W-1:0] != '0);
         end
         // a read clears the flag, but an event in the same cycle wins.
         if (req && !wb_we && wb_adr == ADDR_STATUS) begin
            mismatch_flag <= mismatch_evt;
         end else if (mismatch_evt) begin
            mismatch_flag <= 1'b1;
         end
         if (mismatch_evt && mismatch_cnt != '1) begin
            mismatch_cnt <= mismatch_cnt + 1'b1;
         end
      end
   end

   always_ff @(posedge axi4s_in) begin
      if (req) begin
         case (wb_adr)
            ADDR_CTRL:         wb_dat_r <= WB_DW'(hdr_words);
            ADDR_STATUS:       wb_dat_r <= WB_DW'(mismatch_flag);
            ADDR_MISMATCH_CNT: wb_dat_r <= WB_DW'(mismatch_cnt);
            default:           wb_dat_r <= '0;
         endcase
      end
   end

   a_single_ack: assert property (@(posedge axi4s_in) disable iff (!arst_n)
      wb_ack |=> !wb_ack);

endmodule

// ==== src/stream_pipe.sv ====
/*
 * Stream register slice.
 * Two-entry skid buffer for one valid/ready stream. The payload is
 * registered and ready comes from a flop, at one word per cycle.
 */
`timescale 1ns/1ps

module stream_pipe #(
   parameter int W = 65
) (
   input  logic         axi4s_in,
   input  logic         arst_n,
   input  logic         s_valid,
   output logic         s_ready,
   input  logic [W-1:0] s_data,
   output logic         m_valid,
   input  logic         m_ready,
   output logic [W-1:0] m_data
);

   logic         skid_valid;
   logic [W-1:0] skid_data;
   logic         load_out;

   // the output register can take a new word when empty or draining.
   assign load_out = m_ready || !m_valid;
   assign s_ready  = !skid_valid;

   always_ff @(posedge axi4s_in or negedge arst_n) begin
      if (!arst_n) begin
         m_valid    <= 1'b0;
         skid_valid <= 1'b0;
      end else if (load_out) begin
         m_valid    <= skid_valid || s_valid;
         skid_valid <= 1'b0;
      end else if (s_valid && s_ready) begin
         // receiver stalled with a word in flight, park it.
         skid_valid <= 1'b1;
      end
   end

   always_ff @(posedge axi4s_in) begin
      if (load_out) begin
         m_data <= skid_valid ? skid_data : s_data;
      end
      if (s_valid && s_ready && !load_out) begin
         skid_data <= s_data;
      end
   end

   // a stalled output word holds until it is taken.
   a_hold: assert property (@(posedge axi4s_in) disable iff (!arst_n)
      m_valid && !m_ready |=> m_valid && $stable(m_data));

endmodule

// ==== tb.f ====
src/split_join_pkg.sv
src/stream_pipe.sv
src/hdr_split.sv
src/pyld_fifo.sv
src/hdr_join.sv
src/split_join_regs.sv
src/axi4s_split_join.sv
testbench/tb_split_join.sv

// ==== testbench/tb_split_join.sv ====
/*
 * Testbench for the header split/join stage.
 * Sends LFSR packets, loops the header stream back through an XOR
 * model of the header processor and checks every output word, header
 * flag and register read against a scoreboard.
 */
`timescale 1ns/1ps

module tb_split_join;
   import split_join_pkg::*;

   localparam logic [63:0] XOR_MASK    = 64'h5a5a_0000_0000_a5a5;
   localparam logic [31:0] SEED        = 32'h2374860d;
   localparam logic [31:0] TAPS        = 32'h8020_0003;
   localparam int          NUM_PKTS    = 40;
   localparam int          WATCHDOG_NS = NUM_PKTS * 12 * 4 * 20 + 20000;

   logic axi4s_in, arst_n;
   logic in_valid, in_ready, in_last, out_valid, out_ready, out_last;
   logic [DATA_W-1:0] in_data, out_data, hdr_out_data, hdr_in_data;
   logic hdr_out_valid, hdr_out_ready, hdr_out_last, hdr_out_has_pyld;
   logic hdr_in_valid, hdr_in_ready, hdr_in_last, hdr_in_has_pyld;
   logic [TID_W-1:0] hdr_out_tid, hdr_in_tid;
   logic wb_cyc, wb_stb, wb_we, wb_ack;
   logic [WB_AW-1:0] wb_adr;
   logic [WB_DW-1:0] wb_dat_w, wb_dat_r, wb_exp;
   logic wb_chk, in_taken, hin_taken, out_block;
   logic [31:0] stim_lfsr, stall_lfsr;

   // expected words: {last, data} on out, {has_pyld, tid, last, data} on hdr_out.
   logic [64:0] exp_out [0:1023];
   logic [69:0] exp_hdr [0:1023];
   logic [64:0] out_head;
   logic [69:0] hdr_head;
   logic [69:0] loop_q [$];
   int out_wr, out_rd, hdr_wr, hdr_rd, pkt_cnt, hdr_pkt, corrupt_pkt;
   int out_errs, hdr_errs, wb_errs;

   assign out_head = exp_out[out_rd];
   assign hdr_head = exp_hdr[hdr_rd];

   axi4s_split_join #(.FIFO_DEPTH(16), .IN_PIPE(1'b1), .OUT_PIPE(1'b1),
      .HDR_IN_PIPE(1'b1), .HDR_OUT_PIPE(1'b1)) uut (.*);

   initial begin
      axi4s_in = 1'b0;
      forever #10 axi4s_in = ~axi4s_in;
   end

   initial begin
      #WATCHDOG_NS;
      $display("watchdog timeout, traffic did not drain in time");
      $display("Checks failed");
      $finish;
   end

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ TAPS) : (s >> 1);
   endfunction

   function automatic logic [63:0] stim_bits(input int n);
      logic [63:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[62:0], stim_lfsr[0]};
         stim_lfsr = lfsr_step(stim_lfsr);
      end
      return v;
   endfunction

   function automatic logic stall_bit();
      logic b;
      b = stall_lfsr[0];
      stall_lfsr = lfsr_step(stall_lfsr);
      return b;
   endfunction

   // ----------------------------------------------------------------------
   // transfer monitor and header processor loopback
   // ----------------------------------------------------------------------
   always @(posedge axi4s_in) begin
      in_taken  <= in_valid && in_ready;
      hin_taken <= hdr_in_valid && hdr_in_ready;
      if (arst_n && hdr_out_valid && hdr_out_ready) begin
         // the chosen packet returns with a flipped tag.
         loop_q.push_back({hdr_out_has_pyld,
            hdr_out_tid ^ ((hdr_pkt == corrupt_pkt) ? 4'h1 : 4'h0),
            hdr_out_last, hdr_out_data ^ XOR_MASK});
         hdr_rd <= hdr_rd + 1;
         if (hdr_out_last) hdr_pkt <= hdr_pkt + 1;
      end
      if (arst_n && out_valid && out_ready) out_rd <= out_rd + 1;
   end

   always @(negedge axi4s_in) begin
      if (!hdr_in_valid || hin_taken) begin
         hdr_in_valid = (loop_q.size() != 0);
         if (hdr_in_valid) begin
            {hdr_in_has_pyld, hdr_in_tid, hdr_in_last, hdr_in_data} = loop_q.pop_front();
         end
      end
      out_ready     = !out_block && (stall_bit() | stall_bit());
      hdr_out_ready = stall_bit() | stall_bit();
   end

   // ----------------------------------------------------------------------
   // checks
   // ----------------------------------------------------------------------
   a_out_expected: assert property (@(posedge axi4s_in) disable iff (!arst_n)
      out_valid && out_ready |-> out_rd < out_wr)
      else begin
         out_errs++;
         $display("output word at %0t arrived with no word expected", $time);
      end

   a_out_word: assert property (@(posedge axi4s_in) disable iff (!arst_n)
      out_valid && out_ready |-> {out_last, out_data} == out_head)
      else begin
         out_errs++;
         $display("error %0t out_last/out_data exp %h got %h", $time,
            $sampled(out_head), $sampled({out_last, out_data}));
      end

   a_hdr_word: assert property (@(posedge axi4s_in) disable iff (!arst_n)
      hdr_out_valid && hdr_out_ready |->
         {hdr_out_has_pyld, hdr_out_tid, hdr_out_last, hdr_out_data} == hdr_head)
      else begin
         hdr_errs++;
         $display("error %0t hdr_out has_pyld/tid/last/data exp %h got %h", $time,
            $sampled(hdr_head),
            $sampled({hdr_out_has_pyld, hdr_out_tid, hdr_out_last, hdr_out_data}));
      end

   a_wb_read: assert property (@(posedge axi4s_in) disable iff (!arst_n)
      wb_ack && wb_chk |-> wb_dat_r == wb_exp)
      else begin
         wb_errs++;
         $display("error %0t wb_dat_r exp %h got %h", $time,
            $sampled(wb_exp), $sampled(wb_dat_r));
      end

   a_wb_ack_req: assert property (@(posedge axi4s_in) disable iff (!arst_n)
      wb_ack |-> wb_cyc && wb_stb)
      else begin
         wb_errs++;
         $display("Wishbone ack at %0t without a pending request", $time);
      end

   a_wb_ack_once: assert property (@(posedge axi4s_in) disable iff (!arst_n)
      wb_ack |=> !wb_ack)
      else begin
         wb_errs++;
         $display("Wishbone ack at %0t lasted more than one cycle", $time);
      end

   // ----------------------------------------------------------------------
   // stimulus tasks, called on a falling edge
   // ----------------------------------------------------------------------
   task automatic wb_access(input logic we, input logic [WB_AW-1:0] adr,
                            input logic [WB_DW-1:0] dat, input logic chk);
      int n;
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = adr;
      wb_dat_w = dat;
      wb_exp   = dat;
      wb_chk   = chk;
      n = 0;
      @(negedge axi4s_in);
      while (!wb_ack && n < 16) begin
         @(negedge axi4s_in);
         n++;
      end
      if (!wb_ack) begin
         wb_errs++;
         $display("no Wishbone ack for address %0d within 16 cycles", adr);
      end
      // hold the request over the edge that samples ack.
      @(negedge axi4s_in);
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
      wb_chk = 1'b0;
   endtask

   task automatic send_packet(input int len, input int hw);
      logic [63:0] d;
      logic        to_hdr;
      logic        hlast;
      logic        hpyld;
      for (int i = 0; i < len; i++) begin
         d      = stim_bits(64);
         to_hdr = (hw == 0) || (i < hw);
         hlast  = to_hdr && ((i == len - 1) || (i == hw - 1));
         hpyld  = (hw != 0) && (i == hw - 1) && (len > hw);
         if (to_hdr) begin
            exp_hdr[hdr_wr] = {hpyld, pkt_cnt[3:0], hlast, d};
            hdr_wr++;
         end
         exp_out[out_wr] = {i == len - 1, to_hdr ? (d ^ XOR_MASK) : d};
         out_wr++;
         in_valid = 1'b1;
         in_data  = d;
         in_last  = (i == len - 1);
         @(negedge axi4s_in);
         while (!in_taken) @(negedge axi4s_in);
      end
      in_valid = 1'b0;
      pkt_cnt++;
   endtask

   task automatic drain();
      while (out_rd != out_wr || hdr_rd != hdr_wr) @(negedge axi4s_in);
      repeat (4) @(negedge axi4s_in);
   endtask

   initial begin
      in_valid        = 1'b0;
      in_data         = '0;
      in_last         = 1'b0;
      out_ready       = 1'b0;
      hdr_out_ready   = 1'b0;
      hdr_in_valid    = 1'b0;
      hdr_in_data     = '0;
      hdr_in_last     = 1'b0;
      hdr_in_tid      = '0;
      hdr_in_has_pyld = 1'b0;
      wb_cyc          = 1'b0;
      wb_stb          = 1'b0;
      wb_we           = 1'b0;
      wb_adr          = '0;
      wb_dat_w        = '0;
      wb_exp          = '0;
      wb_chk          = 1'b0;
      in_taken        = 1'b0;
      hin_taken       = 1'b0;
      out_block       = 1'b0;
      corrupt_pkt     = -1;
      stim_lfsr       = SEED;
      stall_lfsr      = SEED;
      arst_n          = 1'b0;
      repeat (16) @(negedge axi4s_in);
      arst_n = 1'b1;
      repeat (2) @(negedge axi4s_in);

      // splitting is off after reset, so packets travel whole.
      wb_access(1'b0, ADDR_CTRL, 32'd0, 1'b1);
      repeat (8) send_packet(1 + stim_bits(4) % 12, 0);
      drain();

      wb_access(1'b1, ADDR_CTRL, 32'h0000_00a5, 1'b0);
      wb_access(1'b0, ADDR_CTRL, 32'h0000_00a5, 1'b1);
      wb_access(1'b1, ADDR_CTRL, 32'd3, 1'b0);
      wb_access(1'b0, ADDR_CTRL, 32'd3, 1'b1);
      repeat (12) send_packet(1 + stim_bits(4) % 12, 3);
      repeat (6) send_packet(1 + stim_bits(2) % 3, 3);

      // a long output stall lets the payload FIFO fill up.
      fork
         repeat (12) send_packet(10 + stim_bits(2) % 3, 3);
         begin
            out_block <= 1'b1;
            repeat (100) @(negedge axi4s_in);
            out_block <= 1'b0;
         end
      join
      drain();
      wb_access(1'b0, ADDR_MISMATCH_CNT, 32'd0, 1'b1);
      wb_access(1'b0, ADDR_STATUS, 32'd0, 1'b1);

      corrupt_pkt = pkt_cnt;
      send_packet(8, 3);
      drain();
      wb_access(1'b0, ADDR_STATUS, 32'd1, 1'b1);
      wb_access(1'b0, ADDR_STATUS, 32'd0, 1'b1);
      wb_access(1'b0, ADDR_MISMATCH_CNT, 32'd1, 1'b1);

      $display("errors: out %0d, hdr_out %0d, wishbone %0d", out_errs, hdr_errs, wb_errs);
      if (out_errs + hdr_errs + wb_errs == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule
